// ==== hdl/stream_consts.svh ====
// stream source width constants shared by the package and the rtl
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// byte address width
`define STREAM_ADDR_W 32

// memory word width
`define STREAM_DATA_W 32

// one strobe bit per byte of a word
`define STREAM_STRB_W 4

// word, line and feature counters
`define STREAM_CNT_W 10

`endif

// ==== hdl/stream_pkg.sv ====
// stream source types for job descriptor, generator flags, memory requests and beats
`default_nettype none
`include "stream_consts.svh"

package stream_pkg;

  // job descriptor, held stable by the caller while the source is busy
  typedef struct packed {
    logic [`STREAM_ADDR_W-1:0] base_addr;   // byte address, may be misaligned
    logic [31:0]               trans_size;  // total words incl. misalignment extras
    logic signed [15:0]        line_stride; // bytes between lines
    logic [15:0]               line_length; // words per line when aligned
    logic signed [15:0]        feat_stride; // bytes between features
    logic [15:0]               feat_length; // lines per feature
  } ctrl_addressgen_t;

  // generator status
  typedef struct packed {
    logic word_update; // word counter steps
    logic line_update; // line counter steps
    logic feat_update; // feature counter steps
    logic first;       // first word of a line
    logic last;        // last word of a line
    logic misaligned;
    logic in_progress; // words left to generate
  } flags_addressgen_t;

  // word-aligned memory request
  typedef struct packed {
    logic [`STREAM_ADDR_W-1:0] addr;
    logic [`STREAM_STRB_W-1:0] strb;
  } mem_req_t;

  // one beat on the output stream
  typedef struct packed {
    logic [`STREAM_DATA_W-1:0] data;
    logic [`STREAM_STRB_W-1:0] strb;
    logic                      last; // final beat of the job
  } stream_beat_t;

endpackage

`default_nettype wire

// ==== hdl/stream_addressgen.sv ====
// strided address generator with word, line and feature loops and misalignment strobes
`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module stream_addressgen (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          enable_i,
  input  logic                          clear_i,
  input  stream_pkg::ctrl_addressgen_t  ctrl_i,
  output stream_pkg::mem_req_t          gen_addr_o,
  output stream_pkg::flags_addressgen_t flags_o
);

  localparam int unsigned OFF_W = $clog2(`STREAM_STRB_W); // byte offset bits
  localparam logic [`STREAM_ADDR_W-1:0] WORD_STEP = `STREAM_ADDR_W'(`STREAM_STRB_W); // bytes per word

  logic [`STREAM_CNT_W-1:0]  word_cnt_q;
  logic [`STREAM_CNT_W-1:0]  line_cnt_q;
  logic [`STREAM_CNT_W-1:0]  feat_cnt_q;
  logic [`STREAM_ADDR_W-1:0] word_off_q;
  logic [`STREAM_ADDR_W-1:0] line_off_q;
  logic [`STREAM_ADDR_W-1:0] feat_off_q;
  logic [31:0]               overall_cnt_q; // words consumed without the extra first word
  logic                      misaligned_q;
  logic                      in_progress_q;

  logic [`STREAM_CNT_W-1:0]  line_last;
  logic [`STREAM_CNT_W-1:0]  feat_last;
  logic [31:0]               final_cnt;
  logic [`STREAM_ADDR_W-1:0] line_step;
  logic [`STREAM_ADDR_W-1:0] feat_step;
  logic [`STREAM_ADDR_W-1:0] addr_sum;
  logic [OFF_W-1:0]          byte_off;
  logic                      word_more;
  logic                      line_more;
  logic                      at_first;
  logic                      at_last;
  logic                      skip_cnt;
  logic [`STREAM_STRB_W-1:0] strb_first;
  logic [`STREAM_STRB_W-1:0] strb;

  // a misaligned line carries one extra word
  assign line_last = misaligned_q ? `STREAM_CNT_W'(ctrl_i.line_length) :
                                    `STREAM_CNT_W'(ctrl_i.line_length - 16'd1);
  assign feat_last = `STREAM_CNT_W'(ctrl_i.feat_length - 16'd1);
  assign final_cnt = ctrl_i.trans_size - (misaligned_q ? 32'd2 : 32'd1);

  assign line_step = {{(`STREAM_ADDR_W-16){ctrl_i.line_stride[15]}}, ctrl_i.line_stride};
  assign feat_step = {{(`STREAM_ADDR_W-16){ctrl_i.feat_stride[15]}}, ctrl_i.feat_stride};

  assign word_more = (word_cnt_q < line_last);
  assign line_more = (line_cnt_q < feat_last);
  assign at_first  = (word_cnt_q == '0);
  assign at_last   = (word_cnt_q == line_last);

  // very first word of a misaligned job is not counted
  assign skip_cnt = misaligned_q & at_first & (line_cnt_q == '0) & (feat_cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt_q    <= '0;
      line_cnt_q    <= '0;
      feat_cnt_q    <= '0;
      word_off_q    <= '0;
      line_off_q    <= '0;
      feat_off_q    <= '0;
      overall_cnt_q <= '0;
    end else if (clear_i) begin
      word_cnt_q    <= '0;
      line_cnt_q    <= '0;
      feat_cnt_q    <= '0;
      word_off_q    <= '0;
      line_off_q    <= '0;
      feat_off_q    <= '0;
      overall_cnt_q <= '0;
    end else if (enable_i) begin
      if (word_more) begin // next word in the line
        word_cnt_q <= word_cnt_q + 1'b1;
        word_off_q <= word_off_q + WORD_STEP;
      end else if (line_more) begin // next line
        word_cnt_q <= '0;
        word_off_q <= '0;
        line_cnt_q <= line_cnt_q + 1'b1;
        line_off_q <= line_off_q + line_step;
      end else begin // next feature
        word_cnt_q <= '0;
        word_off_q <= '0;
        line_cnt_q <= '0;
        line_off_q <= '0;
        feat_cnt_q <= feat_cnt_q + 1'b1;
        feat_off_q <= feat_off_q + feat_step;
      end
      if (!skip_cnt)
        overall_cnt_q <= overall_cnt_q + 32'd1;
    end
  end

  // sampled on clear since the descriptor is stable for the whole job
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      misaligned_q <= 1'b0;
    else if (clear_i)
      misaligned_q <= (ctrl_i.base_addr[OFF_W-1:0] != '0);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      in_progress_q <= 1'b0;
    else if (clear_i)
      in_progress_q <= 1'b1;
    else if (enable_i && !skip_cnt && overall_cnt_q == final_cnt)
      in_progress_q <= 1'b0; // last word consumed
  end

  assign addr_sum = ctrl_i.base_addr + feat_off_q + line_off_q + word_off_q;
  assign byte_off = addr_sum[OFF_W-1:0];

  assign strb_first = {`STREAM_STRB_W{1'b1}} << byte_off;

  always_comb begin
    strb = '1;
    if (misaligned_q) begin
      if (at_last)
        strb = ~strb_first; // tail bytes of the line
      else if (at_first)
        strb = strb_first;
    end
  end

  assign gen_addr_o.addr = {addr_sum[`STREAM_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign gen_addr_o.strb = strb;

  always_comb begin
    flags_o.word_update = enable_i;
    flags_o.line_update = enable_i & ~word_more;
    flags_o.feat_update = enable_i & ~word_more & ~line_more;
    flags_o.first       = at_first;
    flags_o.last        = at_last;
    flags_o.misaligned  = misaligned_q;
    flags_o.in_progress = in_progress_q;
  end

  // strides must keep the byte offset constant across the job
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    enable_i |-> (ctrl_i.line_stride[OFF_W-1:0] == '0 && ctrl_i.feat_stride[OFF_W-1:0] == '0));

  // the controller only steps while words remain
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    enable_i |-> in_progress_q);

endmodule

`default_nettype wire

// ==== hdl/stream_mem_port.sv ====
// four-phase req/ack memory master fetching one word per request
`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module stream_mem_port (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_start_i,
  input  stream_pkg::mem_req_t      gen_addr_i,
  output logic                      fetch_done_o,
  output logic [`STREAM_DATA_W-1:0] fetch_data_o,
  output logic                      mem_req_o,
  output stream_pkg::mem_req_t      mem_addr_o,
  input  logic                      mem_ack_i,
  input  logic [`STREAM_DATA_W-1:0] mem_rdata_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,  // req high until ack
    ST_REL,  // req dropped until ack falls
    ST_DONE
  } state_e;

  state_e                    state_q;
  state_e                    state_d;
  stream_pkg::mem_req_t      addr_q;
  logic [`STREAM_DATA_W-1:0] data_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: if (fetch_start_i) state_d = ST_REQ;
      ST_REQ:  if (mem_ack_i) state_d = ST_REL;
      ST_REL:  if (!mem_ack_i) state_d = ST_DONE;
      ST_DONE: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && fetch_start_i)
      addr_q <= gen_addr_i; // held for the whole handshake
    if (state_q == ST_REQ && mem_ack_i)
      data_q <= mem_rdata_i; // rdata valid with rising ack
  end

  assign mem_req_o    = (state_q == ST_REQ);
  assign mem_addr_o   = addr_q;
  assign fetch_done_o = (state_q == ST_DONE);
  assign fetch_data_o = data_q;

  // ack only answers an open request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_ack_i |-> mem_req_o || state_q == ST_REL);

  // controller waits for fetch_done before the next word
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_start_i |-> state_q == ST_IDLE);

endmodule

`default_nettype wire

// ==== hdl/stream_source_ctrl.sv ====
// stream source controller, sequences fetch, output beat and generator step per word
`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module stream_source_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  output logic                          busy_o,
  input  stream_pkg::flags_addressgen_t gen_flags_i,
  input  logic [`STREAM_STRB_W-1:0]     gen_strb_i,
  output logic                          gen_enable_o,
  output logic                          gen_clear_o,
  output logic                          fetch_start_o,
  input  logic                          fetch_done_i,
  input  logic [`STREAM_DATA_W-1:0]     fetch_data_i,
  output logic                          out_req_o,
  output stream_pkg::stream_beat_t      out_beat_o,
  input  logic                          out_ack_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH, // one-cycle fetch_start
    ST_WAIT,  // memory handshake running
    ST_BEAT,  // out_req high
    ST_DRAIN  // waiting for out_ack to fall
  } state_e;

  state_e                    state_q;
  state_e                    state_d;
  logic [`STREAM_DATA_W-1:0] data_q;
  logic [`STREAM_STRB_W-1:0] strb_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE:  if (start_i) state_d = ST_FETCH;
      ST_FETCH: state_d = ST_WAIT;
      ST_WAIT:  if (fetch_done_i) state_d = ST_BEAT;
      ST_BEAT:  if (out_ack_i) state_d = ST_DRAIN;
      ST_DRAIN: begin
        if (!out_ack_i)
          state_d = gen_flags_i.in_progress ? ST_FETCH : ST_IDLE;
      end
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  assign gen_clear_o   = (state_q == ST_IDLE) & start_i;
  assign fetch_start_o = (state_q == ST_FETCH);
  assign gen_enable_o  = (state_q == ST_WAIT) & fetch_done_i; // step as the beat goes up
  assign out_req_o     = (state_q == ST_BEAT);
  assign busy_o        = (state_q != ST_IDLE);

  always_ff @(posedge clk_i) begin
    if (fetch_start_o)
      strb_q <= gen_strb_i; // strobe of the address being fetched
    if (gen_enable_o)
      data_q <= fetch_data_i;
  end

  // in_progress has fallen by the time the final beat is up
  always_comb begin
    out_beat_o.data = data_q;
    out_beat_o.strb = strb_q;
    out_beat_o.last = ~gen_flags_i.in_progress;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_req_o |=> !out_req_o || $stable(out_beat_o));

endmodule

`default_nettype wire

// ==== hdl/stream_source.sv ====
// stream source top, strided memory reads sent out as a four-phase beat stream
`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module stream_source (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         start_i,
  input  stream_pkg::ctrl_addressgen_t ctrl_i,
  output logic                         busy_o,
  output logic                         mem_req_o,
  output stream_pkg::mem_req_t         mem_addr_o,
  input  logic                         mem_ack_i,
  input  logic [`STREAM_DATA_W-1:0]    mem_rdata_i,
  output logic                         out_req_o,
  output stream_pkg::stream_beat_t     out_beat_o,
  input  logic                         out_ack_i
);

  logic                          gen_enable;
  logic                          gen_clear;
  stream_pkg::mem_req_t          gen_addr;
  stream_pkg::flags_addressgen_t gen_flags;
  logic                          fetch_start;
  logic                          fetch_done;
  logic [`STREAM_DATA_W-1:0]     fetch_data;

  stream_source_ctrl i_ctrl (
    .clk_i, .rst_ni, .start_i, .busy_o,
    .gen_flags_i (gen_flags),
    .gen_strb_i  (gen_addr.strb),
    .gen_enable_o(gen_enable),
    .gen_clear_o (gen_clear),
    .fetch_start_o(fetch_start),
    .fetch_done_i(fetch_done),
    .fetch_data_i(fetch_data),
    .out_req_o, .out_beat_o, .out_ack_i
  );

  stream_addressgen i_addressgen (
    .clk_i, .rst_ni,
    .enable_i  (gen_enable),
    .clear_i   (gen_clear),
    .ctrl_i,
    .gen_addr_o(gen_addr),
    .flags_o   (gen_flags)
  );

  stream_mem_port i_mem_port (
    .clk_i, .rst_ni,
    .fetch_start_i(fetch_start),
    .gen_addr_i   (gen_addr),
    .fetch_done_o (fetch_done),
    .fetch_data_o (fetch_data),
    .mem_req_o, .mem_addr_o, .mem_ack_i, .mem_rdata_i
  );

endmodule

`default_nettype wire

// ==== verif/tb_mem_responder.sv ====
// testbench memory slave, acks four-phase reads after a set delay with address-derived data
`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module tb_mem_responder #(
  parameter logic [`STREAM_DATA_W-1:0] DATA_XOR = 32'h5A5A_C3C3
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [1:0]                delay_i,   // cycles before ack, taken when req is seen
  input  logic                      mem_req_i,
  input  stream_pkg::mem_req_t      mem_addr_i,
  output logic                      mem_ack_o,
  output logic [`STREAM_DATA_W-1:0] mem_rdata_o
);

  logic                      ack_q = 1'b0;
  logic [`STREAM_DATA_W-1:0] rdata_q = '0;
  logic                      pending_q = 1'b0; // request seen, still counting down
  logic [1:0]                wait_q = 2'd0;

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      ack_q     <= 1'b0;
      pending_q <= 1'b0;
    end else if (ack_q) begin
      if (!mem_req_i)
        ack_q <= 1'b0; // close the handshake
    end else if (mem_req_i) begin
      if (pending_q ? (wait_q == 2'd0) : (delay_i == 2'd0)) begin
        ack_q     <= 1'b1;
        rdata_q   <= mem_addr_i.addr ^ DATA_XOR;
        pending_q <= 1'b0;
      end else if (!pending_q) begin
        pending_q <= 1'b1;
        wait_q    <= delay_i - 2'd1;
      end else begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  assign mem_ack_o   = ack_q;
  assign mem_rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== verif/tb_stream_source.sv ====
// testbench for the stream source with random strided jobs checked against a loop model
`timescale 1ns/1ps
`default_nettype none
`include "stream_consts.svh"

module tb_stream_source;

  localparam logic [`STREAM_DATA_W-1:0] DATA_XOR = 32'h5A5A_C3C3;
  localparam int NUM_JOBS = 8;

  logic                         clk_i = 1'b0;
  logic                         rst_ni;
  logic                         start_i;
  stream_pkg::ctrl_addressgen_t ctrl_i;
  logic                         busy_o;
  logic                         mem_req_o;
  stream_pkg::mem_req_t         mem_addr_o;
  logic                         mem_ack_i;
  logic [`STREAM_DATA_W-1:0]    mem_rdata_i;
  logic                         out_req_o;
  stream_pkg::stream_beat_t     out_beat_o;
  logic                         out_ack_i = 1'b0;

  logic [15:0]                  lfsr_q = 16'd59;
  logic [1:0]                   mem_delay = 2'd0;
  logic [1:0]                   out_delay = 2'd0;
  logic                         out_pend_q = 1'b0; // output req seen and ack delayed
  logic [1:0]                   out_wait_q = 2'd0;
  logic                         mem_req_q = 1'b0;
  logic                         out_req_q = 1'b0;
  stream_pkg::mem_req_t         mem_addr_q;
  stream_pkg::stream_beat_t     out_beat_q;
  int unsigned                  cycle_cnt = 0;
  int unsigned                  cycle_limit = 200;
  int unsigned                  total_beats = 0;

  stream_pkg::ctrl_addressgen_t jobs [NUM_JOBS];
  stream_pkg::mem_req_t         exp_mem [$];
  stream_pkg::stream_beat_t     exp_beat [$];

  stream_source i_stream_source (
    .clk_i, .rst_ni, .start_i, .ctrl_i, .busy_o,
    .mem_req_o, .mem_addr_o, .mem_ack_i, .mem_rdata_i,
    .out_req_o, .out_beat_o, .out_ack_i
  );

  tb_mem_responder #(.DATA_XOR(DATA_XOR)) i_mem_responder (
    .clk_i, .rst_ni,
    .delay_i    (mem_delay),
    .mem_req_i  (mem_req_o),
    .mem_addr_i (mem_addr_o),
    .mem_ack_o  (mem_ack_i),
    .mem_rdata_o(mem_rdata_i)
  );

  always #4 clk_i = ~clk_i;

  // galois lfsr stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
      report_failure($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // job 0 aligned, 1 and 3 misaligned, 2 and 3 walk backward
  task automatic make_jobs();
    stream_pkg::ctrl_addressgen_t c;
    int unsigned nfeat;
    for (int j = 0; j < NUM_JOBS; j++) begin
      c.base_addr   = rand_bits(32);
      c.line_length = 16'(1 + rand_bits(2));
      c.feat_length = 16'(1 + rand_bits(2));
      c.line_stride = 16'(4 * (int'(rand_bits(6)) - 32));
      c.feat_stride = 16'(4 * (int'(rand_bits(8)) - 128));
      nfeat = 1 + rand_bits(1);
      if (j == 0)
        c.base_addr[1:0] = 2'b00;
      if ((j == 1 || j == 3) && c.base_addr[1:0] == 2'b00)
        c.base_addr[1:0] = 2'b11;
      if (j == 2 || j == 3) begin
        c.line_stride = 16'(-4 * (1 + int'(rand_bits(5))));
        c.feat_stride = 16'(-64 * (1 + int'(rand_bits(4))));
      end
      c.trans_size = nfeat * c.feat_length * (c.line_length + (c.base_addr[1:0] != 2'b00));
      jobs[j] = c;
      total_beats += c.trans_size;
    end
  endtask

  // expected requests and beats of one job with features outermost
  task automatic build_model(input stream_pkg::ctrl_addressgen_t c);
    int unsigned              wpl;
    int unsigned              n;
    int                       ls;
    int                       fs;
    logic [1:0]               off;
    logic [3:0]               head;
    stream_pkg::mem_req_t     req;
    stream_pkg::stream_beat_t beat;
    off  = c.base_addr[1:0];
    wpl  = c.line_length + (off != 2'd0); // extra word per misaligned line
    ls   = $signed(c.line_stride);
    fs   = $signed(c.feat_stride);
    head = 4'hF << off;
    n    = 0;
    for (int f = 0; n < c.trans_size; f++) begin
      for (int l = 0; l < c.feat_length; l++) begin
        for (int w = 0; w < wpl; w++) begin
          req.addr = c.base_addr + 32'(f * fs + l * ls + 4 * w);
          req.addr[1:0] = 2'b00;
          if (off == 2'd0)
            req.strb = 4'hF;
          else if (w == wpl - 1)
            req.strb = ~head; // tail of the line
          else if (w == 0)
            req.strb = head;
          else
            req.strb = 4'hF;
          beat.data = req.addr ^ DATA_XOR;
          beat.strb = req.strb;
          beat.last = (n == c.trans_size - 1);
          exp_mem.push_back(req);
          exp_beat.push_back(beat);
          n++;
        end
      end
    end
  endtask

  always @(negedge clk_i) begin
    mem_delay <= 2'(rand_bits(2));
    out_delay <= 2'(rand_bits(2));
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
      report_failure($sformatf("timeout after %0d cycles, the source stopped making progress",
                               cycle_cnt));
  end

  // output sink and four-phase monitors on both ports at mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (mem_req_o && !mem_req_q) begin
        if (mem_ack_i)
          report_failure("memory request raised before the previous ack fell");
        else if (exp_mem.size() == 0)
          report_failure("memory request issued with no word left in the job");
        else begin
          check_value("mem_addr_o.addr", mem_addr_o.addr, exp_mem[0].addr);
          check_value("mem_addr_o.strb", mem_addr_o.strb, exp_mem[0].strb);
          void'(exp_mem.pop_front());
        end
      end
      if (out_req_o && !out_req_q) begin
        if (out_ack_i)
          report_failure("output request raised before the previous ack fell");
        else if (exp_beat.size() == 0)
          report_failure("output beat sent with no beat expected");
        else begin
          check_value("out_beat_o.data", out_beat_o.data, exp_beat[0].data);
          check_value("out_beat_o.strb", out_beat_o.strb, exp_beat[0].strb);
          check_value("out_beat_o.last", out_beat_o.last, exp_beat[0].last);
          void'(exp_beat.pop_front());
        end
      end
      if (mem_req_q && !mem_req_o && !mem_ack_i)
        report_failure("memory request dropped before its ack");
      if (out_req_q && !out_req_o && !out_ack_i)
        report_failure("output request dropped before its ack");
      if (mem_req_q && mem_req_o && mem_addr_o !== mem_addr_q)
        report_failure("memory address changed while the request was high");
      if (out_req_q && out_req_o && out_beat_o !== out_beat_q)
        report_failure("output beat changed while the request was high");
      if (out_ack_i) begin
        if (!out_req_o)
          out_ack_i <= 1'b0;
      end else if (out_req_o) begin
        if (out_pend_q ? (out_wait_q == 2'd0) : (out_delay == 2'd0)) begin
          out_ack_i  <= 1'b1;
          out_pend_q <= 1'b0;
        end else if (!out_pend_q) begin
          out_pend_q <= 1'b1;
          out_wait_q <= out_delay - 2'd1;
        end else begin
          out_wait_q <= out_wait_q - 2'd1;
        end
      end
    end
    mem_req_q  <= mem_req_o;
    mem_addr_q <= mem_addr_o;
    out_req_q  <= out_req_o;
    out_beat_q <= out_beat_o;
  end

  initial begin
    rst_ni  = 1'b0;
    start_i = 1'b0;
    ctrl_i  = '0;
    make_jobs();
    cycle_limit = 40 * total_beats + 200;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("busy_o", busy_o, 64'd0);
    check_value("mem_req_o", mem_req_o, 64'd0);
    check_value("out_req_o", out_req_o, 64'd0);
    for (int j = 0; j < NUM_JOBS; j++) begin
      build_model(jobs[j]);
      ctrl_i  = jobs[j];
      start_i = 1'b1;
      @(negedge clk_i);
      start_i = 1'b0;
      check_value("busy_o", busy_o, 64'd1);
      while (busy_o)
        @(negedge clk_i);
      check_value("beats left at busy_o fall", exp_beat.size(), 64'd0);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hdl
hdl/stream_pkg.sv
hdl/stream_addressgen.sv
hdl/stream_mem_port.sv
hdl/stream_source_ctrl.sv
hdl/stream_source.sv
verif/tb_mem_responder.sv
verif/tb_stream_source.sv
